// File: include/core_config.svh
// build constants for the core shell, every count is in clk_74a cycles
// audio numbers assume a 74.25 MHz clk_74a and a 48 kHz output rate
// key positions follow the host controller key bitmap
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////
// audio clocking
////////////////////
// fractional mclk accumulator, 22 bit
// step / wrap = mclk toggles per clk_74a cycle, gives 12.288 MHz
`define AUD_ACCUM_STEP 22'd245760
`define AUD_ACCUM_WRAP 22'd742500
// mclk cycles per serial bit
`define AUD_SCLK_DIV 4
// serial bits per channel slot, active bits at the front
`define I2S_SLOT_BITS 32
`define I2S_SAMPLE_BITS 16

// synchronizer depths for game core inputs
`define AUDIO_SYNC_STAGES 3
`define VIDEO_SYNC_STAGES 2

////////////////////
// controller keys
////////////////////
`define KEY_RIGHT 3
`define KEY_LEFT 2
`define KEY_START 15
`define KEY_FIRE 4
`define KEY_SPARE 7
`define KEY_THRUST 6
`define KEY_HYPER 5

// top address byte of the command region
`define BRIDGE_CMD_REGION 8'hF8

`endif

// File: source/core_pkg.sv
// shared packed types for the core shell
// field order is msb first, so a plain vector view follows the listing
`default_nettype none

package core_pkg;

  ////////////////////
  // audio
  ////////////////////
  // one stereo sample, left in the upper half
  typedef struct packed {
    logic signed [15:0] left;
    logic signed [15:0] right;
  } stereo_sample_t;

  ////////////////////
  // video
  ////////////////////
  // raw game core video, 4 bit colour
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    logic       hs;
    logic       vs;
    logic       hblank;
    logic       vblank;
  } core_video_t;

  // formatted video for the scaler
  typedef struct packed {
    logic [23:0] rgb;
    logic        de;
    logic        hs;
    logic        vs;
    logic        skip;
  } scaler_video_t;

  ////////////////////
  // controls
  ////////////////////
  // arcade button set, each bit active low
  typedef struct packed {
    logic right;
    logic left;
    logic p1_start;
    logic p2_start;
    logic fire;
    logic spare;
    logic thrust;
    logic hyperspace;
  } arcade_buttons_t;

endpackage

`default_nettype wire

// File: source/signal_sync.sv
// register chain for inputs from another clock domain
// a multi-bit payload is only coherent if it is held stable for STAGES cycles
// payload_t must be a packed type
`default_nettype none
`timescale 1ns/10ps

module signal_sync #(
  parameter type payload_t = logic,
  parameter int  STAGES    = 2
) (
  input  wire      clk_74a,
  input  wire      arst_n,
  input  payload_t async_in,
  output payload_t sync_out
);

  // stage 0 catches the async value, last stage is the clean copy
  payload_t stage_q [STAGES];

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < STAGES; i++)
        stage_q[i] <= '0;
    end
    else
    begin
      stage_q[0] <= async_in;
      // shift down the chain
      for (int i = 1; i < STAGES; i++)
        stage_q[i] <= stage_q[i-1];
    end
  end

  assign sync_out = stage_q[STAGES-1];

endmodule

`default_nettype wire

// File: source/i2s_audio_out.sv
// i2s transmitter, all timing from clk_74a enables, no derived clocks
// sample must already be synchronized; it is taken once per frame
// left slot is lrck low, 16 data bits msb first, one bit period after the lrck edge
`default_nettype none
`timescale 1ns/10ps

`include "core_config.svh"

module i2s_audio_out
  import core_pkg::*;
(
  input  wire            clk_74a,
  input  wire            arst_n,
  input  stereo_sample_t sample,
  output logic           audio_mclk,
  output logic           audio_lrck,
  output logic           audio_dac
);

  localparam logic [21:0] ACCUM_STEP  = `AUD_ACCUM_STEP;
  localparam logic [21:0] ACCUM_WRAP  = `AUD_ACCUM_WRAP;
  localparam int          SCLK_DIV    = `AUD_SCLK_DIV;
  localparam int          DIV_W       = $clog2(SCLK_DIV);
  localparam int          SLOT_BITS   = `I2S_SLOT_BITS;
  localparam int          SLOT_W      = $clog2(SLOT_BITS);
  localparam int          SAMPLE_BITS = `I2S_SAMPLE_BITS;
  localparam int          SHIFT_W     = $bits(stereo_sample_t);

  logic [21:0]        accum_q;
  logic               mclk_toggle;
  logic               mclk_rise;
  logic [DIV_W-1:0]   mclk_div_q;
  logic               bit_stb;
  logic [SLOT_W-1:0]  slot_cnt_q;
  logic               slot_last;
  logic               shift_active;
  logic [SHIFT_W-1:0] shift_q;

  ////////////////////
  // mclk generation
  ////////////////////
  // toggle whenever the accumulator reaches the wrap value
  assign mclk_toggle = (accum_q >= ACCUM_WRAP);
  // rising edge detect, mclk is low and about to go high this cycle
  assign mclk_rise = mclk_toggle & ~audio_mclk;

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      accum_q    <= '0;
      audio_mclk <= 1'b0;
    end
    else if (mclk_toggle)
    begin
      accum_q    <= accum_q - ACCUM_WRAP + ACCUM_STEP;
      audio_mclk <= ~audio_mclk;
    end
    else
    begin
      accum_q <= accum_q + ACCUM_STEP;
    end
  end

  ////////////////////
  // bit strobe
  ////////////////////
  // one strobe every SCLK_DIV mclk rising edges
  assign bit_stb = mclk_rise & (mclk_div_q == DIV_W'(SCLK_DIV - 1));

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
      mclk_div_q <= '0;
    else if (mclk_rise)
      mclk_div_q <= mclk_div_q + 1'b1;
  end

  ////////////////////
  // serializer
  ////////////////////
  // slot_cnt is the bit period that just ended
  assign slot_last    = (slot_cnt_q == SLOT_W'(SLOT_BITS - 1));
  // periods 1..16 of the slot carry data
  assign shift_active = (slot_cnt_q < SLOT_W'(SAMPLE_BITS));

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      slot_cnt_q <= '0;
      audio_lrck <= 1'b0;
      audio_dac  <= 1'b0;
      shift_q    <= '0;
    end
    else if (bit_stb)
    begin
      slot_cnt_q <= slot_last ? '0 : slot_cnt_q + 1'b1;
      // period 0 and the padding bits stay low
      audio_dac  <= shift_active & shift_q[SHIFT_W-1];
      if (slot_last)
      begin
        audio_lrck <= ~audio_lrck;
        // high to low starts the left slot, new frame
        if (audio_lrck)
          shift_q <= {sample.left, sample.right};
      end
      else if (shift_active)
      begin
        shift_q <= {shift_q[SHIFT_W-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// File: source/video_out_formatter.sv
// formats core video for the scaler, advances only on pixel_ce
// raw_video must already be synchronized to clk_74a
// sync outputs are one-pixel pulses on the input rising edge
`default_nettype none
`timescale 1ns/10ps

module video_out_formatter
  import core_pkg::*;
(
  input  wire           clk_74a,
  input  wire           arst_n,
  input  wire           pixel_ce,
  input  core_video_t   raw_video,
  output scaler_video_t video_out
);

  logic        active;
  logic [23:0] rgb_expanded;
  logic        hs_prev_q;
  logic        vs_prev_q;

  ////////////////////
  // colour path
  ////////////////////
  // visible area when neither blank is set
  assign active = ~(raw_video.hblank | raw_video.vblank);

  // 4 to 8 bit by nibble duplication, 0xf maps to 0xff
  assign rgb_expanded = {{2{raw_video.r}},
                         {2{raw_video.g}},
                         {2{raw_video.b}}};

  ////////////////////
  // output registers
  ////////////////////
  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      video_out <= '0;
      hs_prev_q <= 1'b0;
      vs_prev_q <= 1'b0;
    end
    else if (pixel_ce)
    begin
      video_out.de <= active;
      // colour is blacked out during blanking
      if (active)
        video_out.rgb <= rgb_expanded;
      else
        video_out.rgb <= '0;

      // rising edge of sync becomes a single pixel pulse
      video_out.hs <= raw_video.hs & ~hs_prev_q;
      video_out.vs <= raw_video.vs & ~vs_prev_q;

      // no frame skipping from this core
      video_out.skip <= 1'b0;

      hs_prev_q <= raw_video.hs;
      vs_prev_q <= raw_video.vs;
    end
  end

endmodule

`default_nettype wire

// File: source/pad_button_map.sv
// two controllers onto one arcade panel
// shared controls respond to either player, start buttons stay per player
// buttons are active low and follow the keys one cycle later
`default_nettype none
`timescale 1ns/10ps

`include "core_config.svh"

module pad_button_map
  import core_pkg::*;
(
  input  wire             clk_74a,
  input  wire             arst_n,
  input  wire [15:0]      cont1_key,
  input  wire [15:0]      cont2_key,
  output arcade_buttons_t buttons
);

  // either player can drive a shared control
  logic [15:0] any_key;

  assign any_key = cont1_key | cont2_key;

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // all released
      buttons <= '1;
    end
    else
    begin
      buttons.right      <= ~any_key[`KEY_RIGHT];
      buttons.left       <= ~any_key[`KEY_LEFT];
      // start is per player
      buttons.p1_start   <= ~cont1_key[`KEY_START];
      buttons.p2_start   <= ~cont2_key[`KEY_START];
      buttons.fire       <= ~any_key[`KEY_FIRE];
      // spare input, unused by the game
      buttons.spare      <= ~any_key[`KEY_SPARE];
      buttons.thrust     <= ~any_key[`KEY_THRUST];
      buttons.hyperspace <= ~any_key[`KEY_HYPER];
    end
  end

endmodule

`default_nettype wire

// File: source/core_top.sv
// core shell top, single clock domain on clk_74a
// core_sample and core_video arrive asynchronous and are synchronized here
// pixel_ce is a one-cycle strobe already on clk_74a
// bridge_rd_data is combinational from bridge_addr
`default_nettype none
`timescale 1ns/10ps

`include "core_config.svh"

module core_top
  import core_pkg::*;
(
  input  wire             clk_74a,
  input  wire             arst_n,

  // game core side
  input  stereo_sample_t  core_sample,
  input  core_video_t     core_video,
  input  wire             pixel_ce,

  // controllers
  input  wire [15:0]      cont1_key,
  input  wire [15:0]      cont2_key,
  output arcade_buttons_t buttons,

  // audio pins
  output logic            audio_mclk,
  output logic            audio_lrck,
  output logic            audio_dac,

  // scaler video
  output scaler_video_t   video_out,

  // bridge read path
  input  wire [31:0]      bridge_addr,
  input  wire [31:0]      cmd_rd_data,
  output logic [31:0]     bridge_rd_data
);

  stereo_sample_t sample_sync;
  core_video_t    video_sync;

  ////////////////////
  // input sync
  ////////////////////
  signal_sync #(
    .payload_t (stereo_sample_t),
    .STAGES    (`AUDIO_SYNC_STAGES)
  ) u_audio_sync (
    .clk_74a  (clk_74a),
    .arst_n   (arst_n),
    .async_in (core_sample),
    .sync_out (sample_sync)
  );

  signal_sync #(
    .payload_t (core_video_t),
    .STAGES    (`VIDEO_SYNC_STAGES)
  ) u_video_sync (
    .clk_74a  (clk_74a),
    .arst_n   (arst_n),
    .async_in (core_video),
    .sync_out (video_sync)
  );

  ////////////////////
  // datapaths
  ////////////////////
  i2s_audio_out u_i2s (
    .clk_74a    (clk_74a),
    .arst_n     (arst_n),
    .sample     (sample_sync),
    .audio_mclk (audio_mclk),
    .audio_lrck (audio_lrck),
    .audio_dac  (audio_dac)
  );

  video_out_formatter u_video (
    .clk_74a   (clk_74a),
    .arst_n    (arst_n),
    .pixel_ce  (pixel_ce),
    .raw_video (video_sync),
    .video_out (video_out)
  );

  pad_button_map u_pads (
    .clk_74a   (clk_74a),
    .arst_n    (arst_n),
    .cont1_key (cont1_key),
    .cont2_key (cont2_key),
    .buttons   (buttons)
  );

  ////////////////////
  // bridge read mux
  ////////////////////
  // only the command region answers, all else reads zero
  always_comb
  begin
    if (bridge_addr[31:24] == `BRIDGE_CMD_REGION)
      bridge_rd_data = cmd_rd_data;
    else
      bridge_rd_data = '0;
  end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// testbench clock and reset source
// reset is released a quarter period after a falling edge, away from both clock edges
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_74a,
  output logic arst_n
);

  initial
  begin
    clk_74a = 1'b0;
    forever #(PERIOD_NS / 2) clk_74a = ~clk_74a;
  end

  // short high phase first so the reset edge is a real negedge
  initial
  begin
    arst_n = 1'b1;
    #5;
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_74a);
    @(negedge clk_74a);
    #(PERIOD_NS / 4);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/core_checker.sv
// watches core_top, holds the reference models and compares on the falling edge
// tests 1,2,5,6 report when test_sel moves on, 3 and 4 when they complete
// mclk rate is counted from reset release regardless of test_sel
`default_nettype none
`timescale 1ns/10ps

`include "core_config.svh"

module core_checker
  import core_pkg::*;
(
  input  wire             clk_74a,
  input  wire             arst_n,
  input  wire [2:0]       test_sel,
  input  wire             probe,
  input  wire [15:0]      cont1_key,
  input  wire [15:0]      cont2_key,
  input  arcade_buttons_t buttons,
  input  wire [31:0]      bridge_addr,
  input  wire [31:0]      cmd_rd_data,
  input  wire [31:0]      bridge_rd_data,
  input  stereo_sample_t  core_sample,
  input  core_video_t     core_video,
  input  scaler_video_t   video_out,
  input  wire             audio_mclk,
  input  wire             audio_lrck,
  input  wire             audio_dac,
  output int              error_count,
  output int              check_count,
  output logic            rate_done,
  output logic            frame_done
);

  localparam int SLOT_BITS   = `I2S_SLOT_BITS;
  localparam int SAMPLE_BITS = `I2S_SAMPLE_BITS;
  localparam int FRAME_EDGES = 2 * SLOT_BITS * `AUD_SCLK_DIV;
  localparam int RATE_CYCLES = 6000;

  int              err_total = 0;
  int              chk_total = 0;
  int              test_checks [8];
  int              test_errors [8];
  logic [2:0]      prev_sel = 3'd0;
  logic            have_keys = 1'b0;
  logic [15:0]     prev_k1;
  logic [15:0]     prev_k2;
  arcade_buttons_t exp_btn;
  scaler_video_t   exp_vid;
  int              hs_high = 0;
  int              vs_high = 0;
  logic            prev_mclk = 1'b0;
  logic            prev_lrck = 1'b0;
  logic            mclk_rise;
  logic            lrck_fell;
  int              rate_cycles = 0;
  int              toggles = 0;
  longint          exp_toggles;
  logic            rate_done_q = 1'b0;
  logic            frame_done_q = 1'b0;
  logic            capturing = 1'b0;
  int              falls = 0;
  int              edge_idx = 0;
  logic [63:0]     dac_bits;

  assign error_count = err_total;
  assign check_count = chk_total;
  assign rate_done   = rate_done_q;
  assign frame_done  = frame_done_q;

  ////////////////////
  // reference models
  ////////////////////
  // shared controls from either pad, starts per pad, all active low
  function automatic arcade_buttons_t map_keys(input logic [15:0] k1, input logic [15:0] k2);
    arcade_buttons_t b;
    logic [15:0]     both;
    both         = k1 | k2;
    b.right      = ~both[`KEY_RIGHT];
    b.left       = ~both[`KEY_LEFT];
    b.p1_start   = ~k1[`KEY_START];
    b.p2_start   = ~k2[`KEY_START];
    b.fire       = ~both[`KEY_FIRE];
    b.spare      = ~both[`KEY_SPARE];
    b.thrust     = ~both[`KEY_THRUST];
    b.hyperspace = ~both[`KEY_HYPER];
    return b;
  endfunction

  function automatic logic [31:0] bridge_ref(input logic [31:0] addr, input logic [31:0] data);
    return (addr[31:24] == `BRIDGE_CMD_REGION) ? data : 32'd0;
  endfunction

  // floor of n*step/wrap toggles after n clock cycles
  function automatic longint mclk_ref(input int n);
    return (longint'(n) * longint'(`AUD_ACCUM_STEP)) / longint'(`AUD_ACCUM_WRAP);
  endfunction

  // dac level in bit period p of a frame with the left slot first
  function automatic logic frame_bit(input stereo_sample_t s, input int p);
    logic [15:0] ch;
    int          j;
    ch = (p >= SLOT_BITS) ? s.right : s.left;
    j  = p % SLOT_BITS;
    if (j >= 1 && j <= SAMPLE_BITS)
      return ch[SAMPLE_BITS - j];
    return 1'b0;
  endfunction

  // expected scaler video with no sync pulse and no skip
  // black and de low in blanking
  function automatic scaler_video_t video_ref(input core_video_t v);
    scaler_video_t s;
    s = '0;
    if (!v.hblank && !v.vblank)
    begin
      s.rgb = {v.r, v.r, v.g, v.g, v.b, v.b};
      s.de  = 1'b1;
    end
    return s;
  endfunction

  ////////////////////
  // bookkeeping
  ////////////////////
  task automatic check_value(input int t, input logic ok, input string msg);
    test_checks[t]++;
    chk_total++;
    if (!ok)
    begin
      test_errors[t]++;
      err_total++;
      $display("FAIL %0t: test %0d %s", $time, t, msg);
    end
  endtask

  task automatic report_test(input int t, input string name);
    $display("test %0d %s: %0d checks, %0d errors", t, name, test_checks[t], test_errors[t]);
  endtask

  ////////////////////
  // comparisons
  ////////////////////
  always @(negedge clk_74a)
  begin
    if (arst_n)
    begin
      mclk_rise = audio_mclk && !prev_mclk;
      lrck_fell = prev_lrck && !audio_lrck;

      // a test ends when the top moves to the next one
      if (test_sel != prev_sel)
      begin
        case (prev_sel)
          3'd1: report_test(1, "button mapping");
          3'd2: report_test(2, "bridge mux");
          3'd5: report_test(5, "video colour");
          3'd6:
          begin
            check_value(6, hs_high == 3, $sformatf("hs high %0d cycles, expected 3", hs_high));
            check_value(6, vs_high == 3, $sformatf("vs high %0d cycles, expected 3", vs_high));
            report_test(6, "sync pulses");
          end
          default: ;
        endcase
      end
      prev_sel = test_sel;

      if (test_sel == 3'd1)
      begin
        // buttons lag the keys by one cycle
        if (have_keys)
        begin
          exp_btn = map_keys(prev_k1, prev_k2);
          check_value(1, buttons == exp_btn,
                      $sformatf("buttons %b expected %b", buttons, exp_btn));
        end
        prev_k1   = cont1_key;
        prev_k2   = cont2_key;
        have_keys = 1'b1;
      end

      if (test_sel == 3'd2)
        check_value(2, bridge_rd_data == bridge_ref(bridge_addr, cmd_rd_data),
                    $sformatf("addr %h read %h expected %h", bridge_addr, bridge_rd_data,
                              bridge_ref(bridge_addr, cmd_rd_data)));

      if (test_sel == 3'd5 && probe)
      begin
        exp_vid = video_ref(core_video);
        check_value(5, video_out == exp_vid,
                    $sformatf("video %h expected %h", video_out, exp_vid));
      end

      if (test_sel == 3'd6)
      begin
        if (video_out.hs)
          hs_high++;
        if (video_out.vs)
          vs_high++;
      end

      // the first clock edge after reset never toggles mclk
      if (!rate_done_q)
      begin
        rate_cycles++;
        if (audio_mclk != prev_mclk)
          toggles++;
        if (rate_cycles == RATE_CYCLES)
        begin
          exp_toggles = mclk_ref(RATE_CYCLES - 1);
          check_value(3, toggles >= exp_toggles - 1 && toggles <= exp_toggles + 1,
                      $sformatf("%0d mclk toggles, expected %0d", toggles, exp_toggles));
          report_test(3, "mclk rate");
          rate_done_q = 1'b1;
        end
      end

      // i2s frame capture starts at edge 0 on the second lrck fall
      if (test_sel == 3'd4 && !frame_done_q && mclk_rise)
      begin
        if (!capturing && lrck_fell)
        begin
          falls++;
          if (falls == 2)
          begin
            capturing = 1'b1;
            edge_idx  = 0;
          end
        end
        if (capturing)
        begin
          if (edge_idx < FRAME_EDGES)
          begin
            check_value(4, audio_lrck == (edge_idx >= FRAME_EDGES / 2),
                        $sformatf("lrck %b at mclk edge %0d", audio_lrck, edge_idx));
            // middle of each bit period
            if (edge_idx % 4 == 2)
              dac_bits[edge_idx / 4] = audio_dac;
            edge_idx++;
          end
          else
          begin
            check_value(4, !audio_lrck, "lrck did not fall after 128 high edges");
            for (int p = 0; p < 64; p++)
              check_value(4, dac_bits[p] == frame_bit(core_sample, p),
                          $sformatf("dac %b in bit period %0d", dac_bits[p], p));
            report_test(4, "i2s frame");
            capturing    = 1'b0;
            frame_done_q = 1'b1;
          end
        end
      end

      prev_mclk = audio_mclk;
      prev_lrck = audio_lrck;
    end
  end

endmodule

`default_nettype wire

// File: verification/core_top_chk.sv
// protocol assertions bound into core_top
// sampled on clk_74a, all but the reset check are off during reset
`default_nettype none
`timescale 1ns/10ps

`include "core_config.svh"

module core_top_chk
  import core_pkg::*;
(
  input wire             clk_74a,
  input wire             arst_n,
  input wire             pixel_ce,
  input wire             audio_mclk,
  input wire             audio_lrck,
  input arcade_buttons_t buttons,
  input wire [31:0]      bridge_addr,
  input wire [31:0]      bridge_rd_data,
  input scaler_video_t   video_out
);

  // hs as produced by the previous pixel strobe
  logic hs_at_last_ce;

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
      hs_at_last_ce <= 1'b0;
    else if (pixel_ce)
      hs_at_last_ce <= video_out.hs;
  end

  buttons_idle_in_reset: assert property (@(posedge clk_74a) !arst_n |-> (buttons == '1))
    else $error("buttons not released during reset");

  bridge_zero_outside: assert property (@(posedge clk_74a) disable iff (!arst_n)
    (bridge_addr[31:24] != `BRIDGE_CMD_REGION) |-> (bridge_rd_data == 32'd0))
    else $error("bridge read data not zero outside the command region");

  hs_single_pixel: assert property (@(posedge clk_74a) disable iff (!arst_n)
    pixel_ce |-> !(video_out.hs && hs_at_last_ce))
    else $error("video hs high on two pixel strobes in a row");

  // lrck only moves with a rising mclk
  lrck_on_mclk_rise: assert property (@(posedge clk_74a) disable iff (!arst_n)
    $changed(audio_lrck) |-> $rose(audio_mclk))
    else $error("lrck changed away from an mclk rising edge");

endmodule

bind core_top core_top_chk u_core_top_chk (
  .clk_74a        (clk_74a),
  .arst_n         (arst_n),
  .pixel_ce       (pixel_ce),
  .audio_mclk     (audio_mclk),
  .audio_lrck     (audio_lrck),
  .buttons        (buttons),
  .bridge_addr    (bridge_addr),
  .bridge_rd_data (bridge_rd_data),
  .video_out      (video_out)
);

`default_nettype wire

// File: verification/tb_core_top.sv
// testbench top for core_top that paces six tests and gives the verdict
// inputs change only on the rising clock edge and pixel_ce comes every 3rd cycle
// run is capped at 20000 cycles to cover the rate count, three audio frames and margin
`default_nettype none
`timescale 1ns/10ps

`include "core_config.svh"

module tb_core_top
  import core_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;

  logic            clk_74a;
  logic            arst_n;
  stereo_sample_t  core_sample;
  core_video_t     core_video;
  logic            pixel_ce = 1'b0;
  logic [15:0]     cont1_key;
  logic [15:0]     cont2_key;
  logic [31:0]     bridge_addr;
  logic [31:0]     cmd_rd_data;
  arcade_buttons_t buttons;
  logic            audio_mclk;
  logic            audio_lrck;
  logic            audio_dac;
  scaler_video_t   video_out;
  logic [31:0]     bridge_rd_data;

  // test pacing towards the checker
  logic [2:0]  test_sel;
  logic        probe;
  int          error_count;
  int          check_count;
  logic        rate_done;
  logic        frame_done;
  int          cycle_count = 0;
  logic [1:0]  ce_div = 2'd0;
  logic [31:0] addr_word;
  core_video_t vid_word;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_clk (
    .clk_74a (clk_74a),
    .arst_n  (arst_n)
  );

  core_top uut (
    .clk_74a        (clk_74a),
    .arst_n         (arst_n),
    .core_sample    (core_sample),
    .core_video     (core_video),
    .pixel_ce       (pixel_ce),
    .cont1_key      (cont1_key),
    .cont2_key      (cont2_key),
    .buttons        (buttons),
    .audio_mclk     (audio_mclk),
    .audio_lrck     (audio_lrck),
    .audio_dac      (audio_dac),
    .video_out      (video_out),
    .bridge_addr    (bridge_addr),
    .cmd_rd_data    (cmd_rd_data),
    .bridge_rd_data (bridge_rd_data)
  );

  core_checker u_check (
    .clk_74a        (clk_74a),
    .arst_n         (arst_n),
    .test_sel       (test_sel),
    .probe          (probe),
    .cont1_key      (cont1_key),
    .cont2_key      (cont2_key),
    .buttons        (buttons),
    .bridge_addr    (bridge_addr),
    .cmd_rd_data    (cmd_rd_data),
    .bridge_rd_data (bridge_rd_data),
    .core_sample    (core_sample),
    .core_video     (core_video),
    .video_out      (video_out),
    .audio_mclk     (audio_mclk),
    .audio_lrck     (audio_lrck),
    .audio_dac      (audio_dac),
    .error_count    (error_count),
    .check_count    (check_count),
    .rate_done      (rate_done),
    .frame_done     (frame_done)
  );

  ////////////////////
  // pixel strobe on one cycle in three
  always @(posedge clk_74a)
  begin
    ce_div   <= (ce_div == 2'd2) ? 2'd0 : ce_div + 2'd1;
    pixel_ce <= (ce_div == 2'd2);
  end

  // counts strobes the DUT has consumed
  task automatic wait_pixels(input int n);
    int seen;
    seen = 0;
    while (seen < n)
    begin
      @(posedge clk_74a);
      if (pixel_ce)
        seen++;
    end
  endtask

  // watchdog
  always @(posedge clk_74a)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////
  // stimulus
  initial
  begin
    void'($urandom(32'h78c3e727));
    core_sample = '0;
    core_video  = '0;
    cont1_key   = '0;
    cont2_key   = '0;
    bridge_addr = '0;
    cmd_rd_data = '0;
    test_sel    = 3'd0;
    probe       = 1'b0;
    @(posedge arst_n);
    @(posedge clk_74a);

    // button mapping with a new key pair every cycle
    test_sel <= 3'd1;
    repeat (200)
    begin
      cont1_key <= 16'($urandom);
      cont2_key <= 16'($urandom);
      @(posedge clk_74a);
    end

    // bridge mux where about half the reads hit the command region
    test_sel <= 3'd2;
    repeat (100)
    begin
      addr_word = $urandom;
      if ($urandom_range(1, 0) == 1)
        addr_word[31:24] = `BRIDGE_CMD_REGION;
      bridge_addr <= addr_word;
      cmd_rd_data <= $urandom;
      @(posedge clk_74a);
    end

    // mclk rate is counted from reset by the checker
    test_sel <= 3'd3;
    wait (rate_done);
    @(posedge clk_74a);

    // one held sample over two frames
    test_sel    <= 3'd4;
    core_sample <= stereo_sample_t'($urandom);
    wait (frame_done);
    @(posedge clk_74a);

    // colour path with a blank set on odd passes
    test_sel <= 3'd5;
    for (int i = 0; i < 20; i++)
    begin
      vid_word    = 16'($urandom);
      vid_word.hs = 1'b0;
      vid_word.vs = 1'b0;
      if (i % 2 == 0)
        {vid_word.hblank, vid_word.vblank} = 2'b00;
      else
        {vid_word.hblank, vid_word.vblank} = 2'($urandom_range(3, 1));
      core_video <= vid_word;
      wait_pixels(4);
      probe <= 1'b1;
      @(posedge clk_74a);
      probe <= 1'b0;
    end

    // sync pulses with each level held 5 strobes
    test_sel   <= 3'd6;
    core_video <= '0;
    wait_pixels(5);
    core_video.hs <= 1'b1;
    wait_pixels(5);
    core_video.hs <= 1'b0;
    wait_pixels(5);
    core_video.vs <= 1'b1;
    wait_pixels(5);
    core_video.vs <= 1'b0;
    wait_pixels(5);

    test_sel <= 3'd7;
    repeat (4) @(posedge clk_74a);

    $display("all tests done: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && check_count > 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
source/core_pkg.sv
source/signal_sync.sv
source/i2s_audio_out.sv
source/video_out_formatter.sv
source/pad_button_map.sv
source/core_top.sv
verification/tb_clock_gen.sv
verification/core_checker.sv
verification/core_top_chk.sv
verification/tb_core_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core_top testbench with Verilator, from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_core_top \
  -Mdir obj_dir -o Vtb_core_top > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_core_top > sim.log 2>&1
cat sim.log

grep -q "^Simulation finished: PASS$" sim.log \
  && echo "run passed" \
  || { echo "run failed, see sim.log"; exit 1; }
